/* Makefile */
TOP = coreTb

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* all.f */
logic/riscvPkg.sv
logic/alu.sv
logic/regFile.sv
logic/branchPredictor.sv
logic/controlUnit.sv
logic/memorySystem.sv
logic/datapath.sv
logic/pipelineCore.sv
verif/coreTb.sv

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import riscvPkg::*; (
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  aluOpE       aluOp_i,
    output logic [31:0] result_o,
    output logic        zero_o
);

    always_comb begin
        case (aluOp_i)
            aluSub:  result_o = a_i - b_i;
            aluAnd:  result_o = a_i & b_i;
            aluOr:   result_o = a_i | b_i;
            aluSlt:  result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            default: result_o = a_i + b_i;
        endcase
    end

    assign zero_o = (result_o == 32'd0);  // Equality test for branches

endmodule

/* logic/branchPredictor.sv */
`timescale 1ns/1ps

module branchPredictor import riscvPkg::*; #(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             pc_i,
    output logic                    predTaken_o,
    output logic [31:0]             predTarget_o,
    output logic [NUM_GHR_BITS-1:0] phtIndex_o,
    input  predUpdateT              update_i
);
    localparam int BTB_IDX_BITS = $clog2(NUM_BTB_ENTRIES);
    localparam int TAG_BITS     = 30 - BTB_IDX_BITS;
    localparam int PHT_ENTRIES  = 1 << NUM_GHR_BITS;

    logic [NUM_GHR_BITS-1:0]    ghr;
    logic [1:0]                 pht [PHT_ENTRIES];
    logic [NUM_BTB_ENTRIES-1:0] btbValid;
    logic [TAG_BITS-1:0]        btbTag [NUM_BTB_ENTRIES];
    logic [31:0]                btbTarget [NUM_BTB_ENTRIES];
    logic [BTB_IDX_BITS-1:0]    readIdx;
    logic [BTB_IDX_BITS-1:0]    writeIdx;
    logic [NUM_GHR_BITS-1:0]    phtWriteIdx;
    logic                       btbHit;

    // gshare index from the PC word bits
    assign phtIndex_o = pc_i[NUM_GHR_BITS+1:2] ^ ghr;
    assign readIdx    = pc_i[BTB_IDX_BITS+1:2];
    assign btbHit     = btbValid[readIdx] && (btbTag[readIdx] == pc_i[31:BTB_IDX_BITS+2]);

    assign predTaken_o  = btbHit && pht[phtIndex_o][1];
    assign predTarget_o = btbTarget[readIdx];

    assign writeIdx    = update_i.btbIndex[BTB_IDX_BITS-1:0];
    assign phtWriteIdx = update_i.phtIndex[NUM_GHR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr      <= '0;
            btbValid <= '0;
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= 2'b01;  // Weakly not taken
            end
        end else begin
            if (update_i.ghrClear) begin
                ghr <= '0;
            end else if (update_i.phtWe) begin
                ghr <= {ghr[NUM_GHR_BITS-2:0], update_i.taken};
            end
            if (update_i.phtWe) begin
                if (update_i.taken && pht[phtWriteIdx] != 2'b11) begin
                    pht[phtWriteIdx] <= pht[phtWriteIdx] + 2'd1;
                end else if (!update_i.taken && pht[phtWriteIdx] != 2'b00) begin
                    pht[phtWriteIdx] <= pht[phtWriteIdx] - 2'd1;
                end
            end
            if (update_i.btbWe) begin
                btbValid[writeIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_i.btbWe) begin
            btbTag[writeIdx]    <= update_i.btbIndex[29:BTB_IDX_BITS];
            btbTarget[writeIdx] <= update_i.btbTarget;
        end
    end

    // Update enables come from the execute stage of the datapath
    assert property (@(posedge clk) disable iff (reset)
        !$isunknown({update_i.phtWe, update_i.btbWe}))
        else $error("predictor write enables unknown");

endmodule

/* logic/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit import riscvPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] op_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7b5_i,
    input  logic [4:0] rs1D_i,
    input  logic [4:0] rs2D_i,
    input  logic [4:0] rs1E_i,
    input  logic [4:0] rs2E_i,
    input  logic [4:0] rdE_i,
    input  logic [4:0] rdM_i,
    input  logic [4:0] rdW_i,
    input  logic       regWriteM_i,
    input  logic       regWriteW_i,
    input  logic       loadE_i,
    input  logic       mispredict_i,
    output ctrlT       ctrlD_o,
    output immSrcE     immSrcD_o,
    output forwardE    forwardA_o,
    output forwardE    forwardB_o,
    output logic       stallF_o,
    output logic       stallD_o,
    output logic       flushD_o,
    output logic       flushE_o
);
    opcodeE opcode;
    aluOpE  aluOpD;
    logic   loadUse;

    assign opcode = opcodeE'(op_i);

    always_comb begin
        case (funct3_i)
            3'b000:  aluOpD = (opcode == opReg && funct7b5_i) ? aluSub : aluAdd;
            3'b010:  aluOpD = aluSlt;
            3'b110:  aluOpD = aluOr;
            3'b111:  aluOpD = aluAnd;
            default: aluOpD = aluAdd;
        endcase
    end

    // Main decoder
    always_comb begin
        ctrlD_o   = '0;
        immSrcD_o = immI;
        case (opcode)
            opLui: begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.resultSrc = resImm;
                immSrcD_o         = immU;
            end
            opImm, opReg: begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.aluOp     = aluOpD;
                ctrlD_o.aluSrcImm = (opcode == opImm);
            end
            opLoad: begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.resultSrc = resMem;
                ctrlD_o.aluSrcImm = 1'b1;
            end
            opStore: begin
                ctrlD_o.memWrite  = 1'b1;
                ctrlD_o.aluSrcImm = 1'b1;
                immSrcD_o         = immS;
            end
            opBranch: begin
                ctrlD_o.branch = 1'b1;
                ctrlD_o.bne    = funct3_i[0];  // beq 000, bne 001
                ctrlD_o.aluOp  = aluSub;
                immSrcD_o      = immB;
            end
            opJal: begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.resultSrc = resPc4;
                ctrlD_o.jump      = 1'b1;
                immSrcD_o         = immJ;
            end
            opJalr: begin
                ctrlD_o.regWrite  = 1'b1;
                ctrlD_o.resultSrc = resPc4;
                ctrlD_o.jump      = 1'b1;
                ctrlD_o.jalr      = 1'b1;
                ctrlD_o.aluSrcImm = 1'b1;  // Target is rs1 + imm
            end
            default: ctrlD_o = '0;
        endcase
    end

    // Memory stage wins over writeback
    function automatic forwardE selectForward(input logic [4:0] rs);
        if (rs != 5'd0 && regWriteM_i && rs == rdM_i) begin
            return fwdMem;
        end else if (rs != 5'd0 && regWriteW_i && rs == rdW_i) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        forwardA_o = selectForward(rs1E_i);
        forwardB_o = selectForward(rs2E_i);
    end

    assign loadUse  = loadE_i && rdE_i != 5'd0 && (rdE_i == rs1D_i || rdE_i == rs2D_i);
    assign stallF_o = loadUse;
    assign stallD_o = loadUse;
    assign flushD_o = mispredict_i;
    assign flushE_o = loadUse || mispredict_i;  // Bubble into execute

    // A load in execute is never also the mispredicted branch
    assert property (@(posedge clk) disable iff (reset) !(stallD_o && mispredict_i))
        else $error("decode stall and mispredict flush in the same cycle");

endmodule

/* logic/datapath.sv */
`timescale 1ns/1ps

module datapath import riscvPkg::*; #(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 8
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr_i,
    input  logic [31:0] readData_i,
    output logic [31:0] pc_o,
    output logic [31:0] dataAddr_o,
    output logic [31:0] writeData_o,
    output logic        memWrite_o,
    output logic [6:0]  op_o,
    output logic [2:0]  funct3_o,
    output logic        funct7b5_o,
    output logic [4:0]  rs1D_o,
    output logic [4:0]  rs2D_o,
    input  ctrlT        ctrlD_i,
    input  immSrcE      immSrcD_i,
    input  forwardE     forwardA_i,
    input  forwardE     forwardB_i,
    input  logic        stallF_i,
    input  logic        stallD_i,
    input  logic        flushD_i,
    input  logic        flushE_i,
    output logic [4:0]  rs1E_o,
    output logic [4:0]  rs2E_o,
    output logic [4:0]  rdE_o,
    output logic [4:0]  rdM_o,
    output logic [4:0]  rdW_o,
    output logic        regWriteM_o,
    output logic        regWriteW_o,
    output logic        loadE_o,
    output retireT      retire_o,
    output logic        mispredict_o
);
    logic [31:0] pcF, pcPlus4F, pcNextF, predTargetF;
    logic        predTakenF;
    logic [NUM_GHR_BITS-1:0] phtIndexF, phtIndexD, phtIndexE;
    logic [31:0] instrD, pcD, pcPlus4D, predTargetD, rd1D, rd2D, immD;
    logic        predTakenD;
    ctrlT        ctrlE, ctrlM, ctrlW;
    logic [31:0] pcE, pcPlus4E, predTargetE, rd1E, rd2E, immE;
    logic [31:0] srcAE, srcBE, writeDataE, aluResultE, targetE, recoverPcE;
    logic        predTakenE, zeroE, takenE, mispredictE;
    predUpdateT  updateE;
    logic [31:0] aluResultM, writeDataM, pcPlus4M, immM, fwdDataM;
    logic [31:0] aluResultW, readDataW, pcPlus4W, immW, resultW;

    branchPredictor #(
        .NUM_BTB_ENTRIES(NUM_BTB_ENTRIES),
        .NUM_GHR_BITS(NUM_GHR_BITS)
    ) i_branchPredictor (
        .clk(clk),
        .reset(reset),
        .pc_i(pcF),
        .predTaken_o(predTakenF),
        .predTarget_o(predTargetF),
        .phtIndex_o(phtIndexF),
        .update_i(updateE)
    );

    // Fetch, repair from execute has priority over the prediction
    assign pcPlus4F = pcF + 32'd4;
    assign pcNextF  = mispredictE ? recoverPcE : (predTakenF ? predTargetF : pcPlus4F);
    assign pc_o     = pcF;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= pcStart;
        end else if (!stallF_i) begin
            pcF <= pcNextF;
        end
    end

    // Decode
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD     <= '0;  // Opcode zero decodes to a bubble
            predTakenD <= 1'b0;
        end else if (!stallD_i) begin
            instrD     <= instr_i;
            predTakenD <= predTakenF;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD         <= pcF;
            pcPlus4D    <= pcPlus4F;
            predTargetD <= predTargetF;
            phtIndexD   <= phtIndexF;
        end
    end

    assign op_o       = instrD[6:0];
    assign funct3_o   = instrD[14:12];
    assign funct7b5_o = instrD[30];
    assign rs1D_o     = instrD[19:15];
    assign rs2D_o     = instrD[24:20];

    regFile i_regFile (
        .clk(clk),
        .a1_i(rs1D_o),
        .a2_i(rs2D_o),
        .a3_i(rdW_o),
        .we3_i(ctrlW.regWrite),
        .wd3_i(resultW),
        .rd1_o(rd1D),
        .rd2_o(rd2D)
    );

    always_comb begin
        case (immSrcD_i)
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'd0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    // Execute
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            ctrlE      <= '0;
            predTakenE <= 1'b0;
        end else begin
            ctrlE      <= ctrlD_i;
            predTakenE <= predTakenD;
        end
    end

    always_ff @(posedge clk) begin
        pcE         <= pcD;
        pcPlus4E    <= pcPlus4D;
        predTargetE <= predTargetD;
        phtIndexE   <= phtIndexD;
        rd1E        <= rd1D;
        rd2E        <= rd2D;
        immE        <= immD;
        rs1E_o      <= rs1D_o;
        rs2E_o      <= rs2D_o;
        rdE_o       <= instrD[11:7];
    end

    always_comb begin
        case (forwardA_i)
            fwdMem:  srcAE = fwdDataM;
            fwdWb:   srcAE = resultW;
            default: srcAE = rd1E;
        endcase
        case (forwardB_i)
            fwdMem:  writeDataE = fwdDataM;
            fwdWb:   writeDataE = resultW;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcBE = ctrlE.aluSrcImm ? immE : writeDataE;

    alu i_alu (
        .a_i(srcAE),
        .b_i(srcBE),
        .aluOp_i(ctrlE.aluOp),
        .result_o(aluResultE),
        .zero_o(zeroE)
    );

    assign takenE  = (ctrlE.branch && (zeroE != ctrlE.bne)) || ctrlE.jump;
    assign targetE = ctrlE.jalr ? (aluResultE & ~32'd1) : pcE + immE;

    // Wrong direction, or taken to a stale BTB target
    assign mispredictE = (takenE != predTakenE) || (takenE && predTargetE != targetE);
    assign recoverPcE  = takenE ? targetE : pcPlus4E;
    assign mispredict_o = mispredictE;

    always_comb begin
        updateE           = '0;
        updateE.phtWe     = ctrlE.branch;
        updateE.taken     = takenE;
        updateE.phtIndex  = PHT_INDEX_BITS'(phtIndexE);
        updateE.btbWe     = takenE;
        updateE.btbIndex  = pcE[31:2];
        updateE.btbTarget = targetE;
        updateE.ghrClear  = mispredictE;
    end

    assign loadE_o = (ctrlE.resultSrc == resMem);

    // Memory
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlM <= '0;
        end else begin
            ctrlM <= ctrlE;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        immM       <= immE;
        rdM_o      <= rdE_o;
    end

    assign dataAddr_o  = aluResultM;
    assign writeData_o = writeDataM;
    assign memWrite_o  = ctrlM.memWrite;
    assign regWriteM_o = ctrlM.regWrite;

    always_comb begin
        case (ctrlM.resultSrc)
            resPc4:  fwdDataM = pcPlus4M;
            resImm:  fwdDataM = immM;
            default: fwdDataM = aluResultM;  // Loads never forward from here
        endcase
    end

    // Writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlW <= '0;
        end else begin
            ctrlW <= ctrlM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultW <= aluResultM;
        readDataW  <= readData_i;
        pcPlus4W   <= pcPlus4M;
        immW       <= immM;
        rdW_o      <= rdM_o;
    end

    always_comb begin
        case (ctrlW.resultSrc)
            resMem:  resultW = readDataW;
            resPc4:  resultW = pcPlus4W;
            resImm:  resultW = immW;
            default: resultW = aluResultW;
        endcase
    end

    assign regWriteW_o = ctrlW.regWrite;
    assign retire_o    = '{valid: ctrlW.regWrite && rdW_o != 5'd0, rd: rdW_o, data: resultW};

    // A wrong-path store behind a mispredict is squashed by the controller
    assert property (@(posedge clk) disable iff (reset) mispredictE |=> !ctrlE.memWrite)
        else $error("store survived an execute flush");

endmodule

/* logic/memorySystem.sv */
`timescale 1ns/1ps

module memorySystem (
    input  logic        clk,
    input  logic [31:0] instrAddr_i,
    output logic [31:0] instr_o,
    input  logic [31:0] dataAddr_i,
    input  logic [31:0] writeData_i,
    input  logic        memWrite_i,
    output logic [31:0] readData_o
);
    logic [31:0] rom [64];
    logic [31:0] ram [64];

    initial begin
        $readmemh("verif/program.hex", rom);
    end

    assign instr_o = rom[instrAddr_i[7:2]];  // Word addressed

    always_ff @(posedge clk) begin
        if (memWrite_i) begin
            ram[dataAddr_i[7:2]] <= writeData_i;
        end
    end

    assign readData_o = ram[dataAddr_i[7:2]];

endmodule

/* logic/pipelineCore.sv */
`timescale 1ns/1ps

module pipelineCore import riscvPkg::*; #(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 8
) (
    input  logic   clk,
    input  logic   reset,
    output retireT retire_o,
    output logic   mispredict_o
);
    logic [31:0] pc, instr, dataAddr, writeData, readData;
    logic        memWrite;
    logic [6:0]  op;
    logic [2:0]  funct3;
    logic        funct7b5;
    logic [4:0]  rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
    logic        regWriteM, regWriteW, loadE;
    ctrlT        ctrlD;
    immSrcE      immSrcD;
    forwardE     forwardA, forwardB;
    logic        stallF, stallD, flushD, flushE;

    controlUnit i_controlUnit (
        .clk(clk),
        .reset(reset),
        .op_i(op),
        .funct3_i(funct3),
        .funct7b5_i(funct7b5),
        .rs1D_i(rs1D),
        .rs2D_i(rs2D),
        .rs1E_i(rs1E),
        .rs2E_i(rs2E),
        .rdE_i(rdE),
        .rdM_i(rdM),
        .rdW_i(rdW),
        .regWriteM_i(regWriteM),
        .regWriteW_i(regWriteW),
        .loadE_i(loadE),
        .mispredict_i(mispredict_o),
        .ctrlD_o(ctrlD),
        .immSrcD_o(immSrcD),
        .forwardA_o(forwardA),
        .forwardB_o(forwardB),
        .stallF_o(stallF),
        .stallD_o(stallD),
        .flushD_o(flushD),
        .flushE_o(flushE)
    );

    datapath #(
        .NUM_BTB_ENTRIES(NUM_BTB_ENTRIES),
        .NUM_GHR_BITS(NUM_GHR_BITS)
    ) i_datapath (
        .clk(clk),
        .reset(reset),
        .instr_i(instr),
        .readData_i(readData),
        .pc_o(pc),
        .dataAddr_o(dataAddr),
        .writeData_o(writeData),
        .memWrite_o(memWrite),
        .op_o(op),
        .funct3_o(funct3),
        .funct7b5_o(funct7b5),
        .rs1D_o(rs1D),
        .rs2D_o(rs2D),
        .ctrlD_i(ctrlD),
        .immSrcD_i(immSrcD),
        .forwardA_i(forwardA),
        .forwardB_i(forwardB),
        .stallF_i(stallF),
        .stallD_i(stallD),
        .flushD_i(flushD),
        .flushE_i(flushE),
        .rs1E_o(rs1E),
        .rs2E_o(rs2E),
        .rdE_o(rdE),
        .rdM_o(rdM),
        .rdW_o(rdW),
        .regWriteM_o(regWriteM),
        .regWriteW_o(regWriteW),
        .loadE_o(loadE),
        .retire_o(retire_o),
        .mispredict_o(mispredict_o)
    );

    memorySystem i_memorySystem (
        .clk(clk),
        .instrAddr_i(pc),
        .instr_o(instr),
        .dataAddr_i(dataAddr),
        .writeData_i(writeData),
        .memWrite_i(memWrite),
        .readData_o(readData)
    );

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic [4:0]  a1_i,
    input  logic [4:0]  a2_i,
    input  logic [4:0]  a3_i,
    input  logic        we3_i,
    input  logic [31:0] wd3_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we3_i && a3_i != 5'd0) begin
            regs[a3_i] <= wd3_i;
        end
    end

    // x0 reads zero, a same-cycle write is passed straight through
    assign rd1_o = (a1_i == 5'd0) ? 32'd0 : (we3_i && a3_i == a1_i) ? wd3_i : regs[a1_i];
    assign rd2_o = (a2_i == 5'd0) ? 32'd0 : (we3_i && a3_i == a2_i) ? wd3_i : regs[a2_i];

endmodule

/* logic/riscvPkg.sv */
package riscvPkg;

    localparam logic [31:0] pcStart = 32'h0;
    localparam int PHT_INDEX_BITS = 16;  // Widest counter index the update bundle carries

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpE;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immJ,
        immU
    } immSrcE;

    typedef enum logic [1:0] {
        fwdReg,  // Value read in decode
        fwdMem,
        fwdWb
    } forwardE;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPc4,
        resImm
    } resultSrcE;

    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        resultSrcE resultSrc;
        aluOpE     aluOp;
        logic      aluSrcImm;
        logic      branch;
        logic      bne;     // Branch on not equal
        logic      jump;    // jal or jalr
        logic      jalr;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } retireT;

    typedef struct packed {
        logic                      phtWe;
        logic                      taken;
        logic [PHT_INDEX_BITS-1:0] phtIndex;
        logic                      btbWe;
        logic [29:0]               btbIndex;  // Word address, low bits index and the rest tag
        logic [31:0]               btbTarget;
        logic                      ghrClear;  // Mispredict seen in execute
    } predUpdateT;

endpackage

/* verif/coreTb.sv */
`timescale 1ns/1ps

module coreTb import riscvPkg::*; ();
    localparam int RETIRE_TIMEOUT = 200;  // Cycles allowed between two retires
    localparam int QUIET_CYCLES   = 30;
    localparam int LOOP_TRIPS     = 8;

    logic   clk;
    logic   reset;
    retireT retire;
    logic   mispredict;

    retireT expectedQ [$];
    string  nameQ [$];
    int     loopStart;  // Table index of the first loop retire
    int     afterLoop;  // First retire past the loop
    int     mispredictCount;
    int     countBeforeLoop;
    int     countAfterLoop;

    pipelineCore i_pipelineCore (
        .clk(clk),
        .reset(reset),
        .retire_o(retire),
        .mispredict_o(mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            mispredictCount <= 0;
        end else if (mispredict) begin
            mispredictCount <= mispredictCount + 1;
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkRetire(input string name, input retireT expected, input retireT actual);
        if (actual !== expected) begin
            abortRun($sformatf(
                "mismatch %s: expected valid=%0b rd=x%0d data=%08h, actual valid=%0b rd=x%0d data=%08h",
                name, expected.valid, expected.rd, expected.data,
                actual.valid, actual.rd, actual.data));
        end
    endtask

    task automatic checkCount(input string name, input int lowest, input int highest,
                              input int actual);
        if (actual < lowest || actual > highest) begin
            abortRun($sformatf("mismatch %s: expected %0d to %0d, actual %0d",
                               name, lowest, highest, actual));
        end
    endtask

    task automatic addExpected(input string name, input logic [4:0] rd, input logic [31:0] data);
        retireT entry;
        entry.valid = 1'b1;
        entry.rd    = rd;
        entry.data  = data;
        expectedQ.push_back(entry);
        nameQ.push_back(name);
    endtask

    // Retire order of verif/program.hex, values follow RV32I semantics
    task automatic buildTable();
        int trip;
        addExpected("lui x1", 5'd1, 32'h1234_5000);
        addExpected("addi x2", 5'd2, 32'd100);
        addExpected("addi x3", 5'd3, 32'hFFFF_FFF9);  // -7
        addExpected("add x4 forwarded", 5'd4, 32'd100 - 32'd7);
        addExpected("sub x5", 5'd5, 32'd93 - 32'd100);
        addExpected("and x6", 5'd6, 32'h0000_005D & 32'hFFFF_FFF9);
        addExpected("or x7", 5'd7, 32'h1234_5000 | 32'd100);
        addExpected("slt x8 true", 5'd8, 32'd1);  // Signed -7 < 100
        addExpected("slt x9 false", 5'd9, 32'd0);
        addExpected("addi x10 base", 5'd10, 32'h40);
        addExpected("lw x11 after sw", 5'd11, 32'd93);
        addExpected("add x12 load use", 5'd12, 32'd93 + 32'd100);
        addExpected("addi x5 clear", 5'd5, 32'd0);
        addExpected("addi x6 limit", 5'd6, 32'd8);
        loopStart = expectedQ.size();
        for (trip = 1; trip <= LOOP_TRIPS; trip++) begin
            addExpected($sformatf("loop count %0d", trip), 5'd5, trip);
        end
        afterLoop = expectedQ.size();
        addExpected("addi x13 after loop", 5'd13, 32'd8 + 32'd10);
        addExpected("addi x14", 5'd14, 32'h60);
        addExpected("jal link x15", 5'd15, 32'h4C + 32'd4);
        addExpected("jalr link x18", 5'd18, 32'h58 + 32'd4);
        addExpected("add x19 at jalr target", 5'd19, 32'h50 + 32'h5C);
        addExpected("lw x20 marker", 5'd20, 32'hAC);  // Read back of the marker store
    endtask

    task automatic waitRetire(input string name, output retireT seen);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retire.valid) begin
            cycles++;
            if (cycles >= RETIRE_TIMEOUT) begin
                abortRun($sformatf("timeout: %s did not retire within %0d cycles",
                                   name, RETIRE_TIMEOUT));
            end
            @(negedge clk);
        end
        seen = retire;
    endtask

    initial begin
        retireT seen;
        int     extraRetires;
        reset = 1'b1;
        buildTable();
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        for (int idx = 0; idx < expectedQ.size(); idx++) begin
            waitRetire(nameQ[idx], seen);
            checkRetire(nameQ[idx], expectedQ[idx], seen);
            if (idx == loopStart - 1) begin
                countBeforeLoop = mispredictCount;  // Loop branch not yet resolved
            end
            if (idx == afterLoop) begin
                countAfterLoop = mispredictCount;  // The jal is still in execute here
            end
        end

        // Cold BTB forces one miss, a trained counter keeps it under one per trip
        checkCount("loop mispredicts", 1, LOOP_TRIPS - 1, countAfterLoop - countBeforeLoop);

        // Program parks in a self loop that writes x0
        extraRetires = 0;
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (retire.valid) begin
                extraRetires++;
            end
        end
        checkCount("retires after program end", 0, 0, extraRetires);

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* verif/program.hex */
// One 32-bit instruction word per line, loaded from address 0
// Trailing comment gives the byte address and the instruction
123450B7  // 00 lui  x1, 0x12345
06400113  // 04 addi x2, x0, 100
FF900193  // 08 addi x3, x0, -7
00310233  // 0c add  x4, x2, x3
402202B3  // 10 sub  x5, x4, x2
00327333  // 14 and  x6, x4, x3
0020E3B3  // 18 or   x7, x1, x2
0021A433  // 1c slt  x8, x3, x2
003124B3  // 20 slt  x9, x2, x3
04000513  // 24 addi x10, x0, 0x40
00452023  // 28 sw   x4, 0(x10)
00052583  // 2c lw   x11, 0(x10)
00258633  // 30 add  x12, x11, x2
00000293  // 34 addi x5, x0, 0
00800313  // 38 addi x6, x0, 8
00128293  // 3c addi x5, x5, 1
FE629EE3  // 40 bne  x5, x6, -4
00A28693  // 44 addi x13, x5, 10
06000713  // 48 addi x14, x0, 0x60
00C007EF  // 4c jal  x15, +12
06F00813  // 50 addi x16, x0, 111 skipped
0DE00813  // 54 addi x16, x0, 222 skipped
00C70967  // 58 jalr x18, 12(x14)
14D00813  // 5c addi x16, x0, 333 skipped
1BC00813  // 60 addi x16, x0, 444 skipped
22B00813  // 64 addi x16, x0, 555 skipped
29A00813  // 68 addi x16, x0, 666 skipped
012789B3  // 6c add  x19, x15, x18
01352223  // 70 sw   x19, 4(x10) marker
00452A03  // 74 lw   x20, 4(x10)
0000006F  // 78 jal  x0, 0
00000013  // 7c nop
